// File: design/idec_pkg.sv
`default_nettype none

package idec_pkg;

    localparam int unsigned INST_W    = 32;
    localparam int unsigned REG_IDX_W = 5;

    // ************************************************************
    // opcode classes and control encodings
    // ************************************************************

    // grouped so that the control table can work on ranges
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_NOR, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_SLTI, OP_SLTUI, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LU12I, OP_PCADDU12I, OP_JIRL, OP_B, OP_BL,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU, OP_STB, OP_STH, OP_STW,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic [1:0] {GTYPE_INT, GTYPE_BW, GTYPE_SFT, GTYPE_LI} alu_gtype_e;

    // operation codes restart inside each gtype group
    typedef logic [2:0] alu_stype_e;
    localparam alu_stype_e ALU_ADD     = 3'd0;
    localparam alu_stype_e ALU_SUB     = 3'd1;
    localparam alu_stype_e ALU_SLT     = 3'd2;
    localparam alu_stype_e ALU_SLTU    = 3'd3;
    localparam alu_stype_e ALU_NOR     = 3'd0;
    localparam alu_stype_e ALU_AND     = 3'd1;
    localparam alu_stype_e ALU_OR      = 3'd2;
    localparam alu_stype_e ALU_XOR     = 3'd3;
    localparam alu_stype_e ALU_SLL     = 3'd0;
    localparam alu_stype_e ALU_SRL     = 3'd1;
    localparam alu_stype_e ALU_SRA     = 3'd2;
    localparam alu_stype_e ALU_PCPLUS4 = 3'd0;
    localparam alu_stype_e ALU_LUI     = 3'd1;
    localparam alu_stype_e ALU_PCADDUI = 3'd2;

    typedef enum logic [2:0] {
        CMP_NONE, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_e;

    typedef enum logic [2:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_UBYTE, MEM_UHALF} mem_type_e;

    typedef enum logic [1:0] {SRC0_NONE, SRC0_RD, SRC0_RK, SRC0_IMM} src0_sel_e;
    typedef enum logic       {SRC1_NONE, SRC1_RJ} src1_sel_e;
    typedef enum logic [1:0] {WR_NONE, WR_RD, WR_LINK} wr_sel_e; // link writes r1

    typedef enum logic [2:0] {
        IMM_NONE, IMM_U5, IMM_U12, IMM_S12, IMM_S20, IMM_S16, IMM_S26
    } imm_kind_e;

    // ************************************************************
    // instruction formats
    // ************************************************************

    typedef struct packed {
        logic [16:0]          opcode;
        logic [REG_IDX_W-1:0] rk; // also ui5 of the immediate shifts
        logic [REG_IDX_W-1:0] rj;
        logic [REG_IDX_W-1:0] rd;
    } fmt_3r_s;

    typedef struct packed {
        logic [9:0]           opcode;
        logic [11:0]          si12;
        logic [REG_IDX_W-1:0] rj;
        logic [REG_IDX_W-1:0] rd;
    } fmt_2ri12_s;

    typedef struct packed {
        logic [6:0]           opcode;
        logic [19:0]          si20;
        logic [REG_IDX_W-1:0] rd;
    } fmt_1ri20_s;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [15:0]          offs16;
        logic [REG_IDX_W-1:0] rj;
        logic [REG_IDX_W-1:0] rd;
    } fmt_2ri16_s;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [9:0]  offs_hi10; // upper part of the 26-bit offset
    } fmt_i26_s;

    typedef union packed {
        logic [INST_W-1:0] word;
        fmt_3r_s           fmt_3r;
        fmt_2ri12_s        fmt_2ri12;
        fmt_1ri20_s        fmt_1ri20;
        fmt_2ri16_s        fmt_2ri16;
        fmt_i26_s          fmt_i26;
    } inst_fmt_u;

    // ************************************************************
    // stage records
    // ************************************************************

    typedef struct packed {
        logic      valid;
        logic      err;
        op_class_e op_class;
        inst_fmt_u inst;
    } match_s;

    typedef struct packed {
        logic       valid;
        logic       err;
        inst_fmt_u  inst;
        alu_gtype_e alu_gtype;
        alu_stype_e alu_stype;
        cmp_e       cmp;
        logic       jump;
        logic       target_abs;
        logic       mem_read;
        logic       mem_write;
        mem_type_e  mem_type;
        src0_sel_e  src0_sel;
        src1_sel_e  src1_sel;
        wr_sel_e    wr_sel;
        imm_kind_e  imm_kind;
    } ctrl_s;

    typedef struct packed {
        logic                 err;
        alu_gtype_e           alu_gtype;
        alu_stype_e           alu_stype;
        cmp_e                 cmp;
        logic                 jump;
        logic                 target_abs;
        logic                 mem_read;
        logic                 mem_write;
        mem_type_e            mem_type;
        logic                 rs0_en;
        logic [REG_IDX_W-1:0] rs0_idx;
        logic                 use_imm;
        logic                 rs1_en;
        logic [REG_IDX_W-1:0] rs1_idx;
        logic                 wr_en;
        logic [REG_IDX_W-1:0] wr_idx;
        logic [INST_W-1:0]    imm;
    } decoded_s;

endpackage

`default_nettype wire

// File: design/opcode_match_stage.sv
`timescale 1ns/100ps
`default_nettype none

module opcode_match_stage (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         valid_i,
    input  wire [idec_pkg::INST_W-1:0]  inst_i,
    output idec_pkg::match_s            match_o
);

    idec_pkg::op_class_e class_d;

    always_comb begin
        priority casez (inst_i)
            // register-register, 3R format
            32'b00000000000100000_?????_?????_?????: class_d = idec_pkg::OP_ADD;
            32'b00000000000100010_?????_?????_?????: class_d = idec_pkg::OP_SUB;
            32'b00000000000100100_?????_?????_?????: class_d = idec_pkg::OP_SLT;
            32'b00000000000100101_?????_?????_?????: class_d = idec_pkg::OP_SLTU;
            32'b00000000000101000_?????_?????_?????: class_d = idec_pkg::OP_NOR;
            32'b00000000000101001_?????_?????_?????: class_d = idec_pkg::OP_AND;
            32'b00000000000101010_?????_?????_?????: class_d = idec_pkg::OP_OR;
            32'b00000000000101011_?????_?????_?????: class_d = idec_pkg::OP_XOR;
            32'b00000000000101110_?????_?????_?????: class_d = idec_pkg::OP_SLL;
            32'b00000000000101111_?????_?????_?????: class_d = idec_pkg::OP_SRL;
            32'b00000000000110000_?????_?????_?????: class_d = idec_pkg::OP_SRA;
            32'b00000000010000001_?????_?????_?????: class_d = idec_pkg::OP_SLLI;
            32'b00000000010001001_?????_?????_?????: class_d = idec_pkg::OP_SRLI;
            32'b00000000010010001_?????_?????_?????: class_d = idec_pkg::OP_SRAI;
            // 12-bit immediate ALU, 2RI12 format
            32'b0000001000_????_????_????_?????_?????: class_d = idec_pkg::OP_SLTI;
            32'b0000001001_????_????_????_?????_?????: class_d = idec_pkg::OP_SLTUI;
            32'b0000001010_????_????_????_?????_?????: class_d = idec_pkg::OP_ADDI;
            32'b0000001101_????_????_????_?????_?????: class_d = idec_pkg::OP_ANDI;
            32'b0000001110_????_????_????_?????_?????: class_d = idec_pkg::OP_ORI;
            32'b0000001111_????_????_????_?????_?????: class_d = idec_pkg::OP_XORI;
            32'b0001010_????_????_????_????_????_?????: class_d = idec_pkg::OP_LU12I;
            32'b0001110_????_????_????_????_????_?????: class_d = idec_pkg::OP_PCADDU12I;
            // jumps and branches
            32'b010011_????_????_????_????_?????_?????: class_d = idec_pkg::OP_JIRL;
            32'b010100_????_????_????_????_?????_?????: class_d = idec_pkg::OP_B;
            32'b010101_????_????_????_????_?????_?????: class_d = idec_pkg::OP_BL;
            32'b010110_????_????_????_????_?????_?????: class_d = idec_pkg::OP_BEQ;
            32'b010111_????_????_????_????_?????_?????: class_d = idec_pkg::OP_BNE;
            32'b011000_????_????_????_????_?????_?????: class_d = idec_pkg::OP_BLT;
            32'b011001_????_????_????_????_?????_?????: class_d = idec_pkg::OP_BGE;
            32'b011010_????_????_????_????_?????_?????: class_d = idec_pkg::OP_BLTU;
            32'b011011_????_????_????_????_?????_?????: class_d = idec_pkg::OP_BGEU;
            // loads and stores
            32'b0010100000_????_????_????_?????_?????: class_d = idec_pkg::OP_LDB;
            32'b0010100001_????_????_????_?????_?????: class_d = idec_pkg::OP_LDH;
            32'b0010100010_????_????_????_?????_?????: class_d = idec_pkg::OP_LDW;
            32'b0010100100_????_????_????_?????_?????: class_d = idec_pkg::OP_STB;
            32'b0010100101_????_????_????_?????_?????: class_d = idec_pkg::OP_STH;
            32'b0010100110_????_????_????_?????_?????: class_d = idec_pkg::OP_STW;
            32'b0010101000_????_????_????_?????_?????: class_d = idec_pkg::OP_LDBU;
            32'b0010101001_????_????_????_?????_?????: class_d = idec_pkg::OP_LDHU;
            default:                                  class_d = idec_pkg::OP_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            match_o.valid <= 1'b0;
        end else begin
            match_o.valid <= valid_i;
        end
        match_o.err      <= (class_d == idec_pkg::OP_ILLEGAL); // dropped opcodes land here too
        match_o.op_class <= class_d;
        match_o.inst     <= inst_i;
    end

endmodule

`default_nettype wire

// File: design/control_gen_stage.sv
`timescale 1ns/100ps
`default_nettype none

module control_gen_stage (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire idec_pkg::match_s   match_i,
    output idec_pkg::ctrl_s         ctrl_o
);

    idec_pkg::op_class_e cls;
    idec_pkg::ctrl_s     ctrl_d;

    assign cls = match_i.op_class;

    always_comb begin
        ctrl_d       = '0; // OP_ILLEGAL matches nothing below, so errors keep all enables low
        ctrl_d.valid = match_i.valid;
        ctrl_d.err   = match_i.err;
        ctrl_d.inst  = match_i.inst;

        // ************************************************************
        // ALU group and operation
        // ************************************************************
        case (cls) inside
            [idec_pkg::OP_NOR:idec_pkg::OP_XOR], [idec_pkg::OP_ANDI:idec_pkg::OP_XORI]:
                ctrl_d.alu_gtype = idec_pkg::GTYPE_BW;
            [idec_pkg::OP_SLL:idec_pkg::OP_SRA], [idec_pkg::OP_SLLI:idec_pkg::OP_SRAI]:
                ctrl_d.alu_gtype = idec_pkg::GTYPE_SFT;
            [idec_pkg::OP_LU12I:idec_pkg::OP_JIRL], idec_pkg::OP_BL:
                ctrl_d.alu_gtype = idec_pkg::GTYPE_LI;
            default: ctrl_d.alu_gtype = idec_pkg::GTYPE_INT;
        endcase

        case (cls)
            idec_pkg::OP_ADD, idec_pkg::OP_ADDI:   ctrl_d.alu_stype = idec_pkg::ALU_ADD;
            idec_pkg::OP_SUB:                      ctrl_d.alu_stype = idec_pkg::ALU_SUB;
            idec_pkg::OP_SLT, idec_pkg::OP_SLTI:   ctrl_d.alu_stype = idec_pkg::ALU_SLT;
            idec_pkg::OP_SLTU, idec_pkg::OP_SLTUI: ctrl_d.alu_stype = idec_pkg::ALU_SLTU;
            idec_pkg::OP_NOR:                      ctrl_d.alu_stype = idec_pkg::ALU_NOR;
            idec_pkg::OP_AND, idec_pkg::OP_ANDI:   ctrl_d.alu_stype = idec_pkg::ALU_AND;
            idec_pkg::OP_OR, idec_pkg::OP_ORI:     ctrl_d.alu_stype = idec_pkg::ALU_OR;
            idec_pkg::OP_XOR, idec_pkg::OP_XORI:   ctrl_d.alu_stype = idec_pkg::ALU_XOR;
            idec_pkg::OP_SLL, idec_pkg::OP_SLLI:   ctrl_d.alu_stype = idec_pkg::ALU_SLL;
            idec_pkg::OP_SRL, idec_pkg::OP_SRLI:   ctrl_d.alu_stype = idec_pkg::ALU_SRL;
            idec_pkg::OP_SRA, idec_pkg::OP_SRAI:   ctrl_d.alu_stype = idec_pkg::ALU_SRA;
            idec_pkg::OP_JIRL, idec_pkg::OP_BL:    ctrl_d.alu_stype = idec_pkg::ALU_PCPLUS4;
            idec_pkg::OP_LU12I:                    ctrl_d.alu_stype = idec_pkg::ALU_LUI;
            idec_pkg::OP_PCADDU12I:                ctrl_d.alu_stype = idec_pkg::ALU_PCADDUI;
            default: ;
        endcase

        // ************************************************************
        // operand sources, destination and immediate kind
        // ************************************************************
        case (cls) inside
            [idec_pkg::OP_ADD:idec_pkg::OP_SRA]:
                ctrl_d.src0_sel = idec_pkg::SRC0_RK;
            [idec_pkg::OP_SLTI:idec_pkg::OP_PCADDU12I]:
                ctrl_d.src0_sel = idec_pkg::SRC0_IMM;
            [idec_pkg::OP_BEQ:idec_pkg::OP_BGEU], [idec_pkg::OP_STB:idec_pkg::OP_STW]:
                ctrl_d.src0_sel = idec_pkg::SRC0_RD; // compare operand or store data
            default: ;
        endcase

        if (cls inside {[idec_pkg::OP_ADD:idec_pkg::OP_SRAI], idec_pkg::OP_JIRL,
                        [idec_pkg::OP_BEQ:idec_pkg::OP_STW]}) begin
            ctrl_d.src1_sel = idec_pkg::SRC1_RJ;
        end

        case (cls) inside
            [idec_pkg::OP_ADD:idec_pkg::OP_JIRL], [idec_pkg::OP_LDB:idec_pkg::OP_LDHU]:
                ctrl_d.wr_sel = idec_pkg::WR_RD;
            idec_pkg::OP_BL: ctrl_d.wr_sel = idec_pkg::WR_LINK;
            default: ;
        endcase

        case (cls) inside
            [idec_pkg::OP_SLTI:idec_pkg::OP_ADDI], [idec_pkg::OP_LDB:idec_pkg::OP_STW]:
                ctrl_d.imm_kind = idec_pkg::IMM_S12;
            [idec_pkg::OP_ANDI:idec_pkg::OP_XORI]: ctrl_d.imm_kind = idec_pkg::IMM_U12;
            [idec_pkg::OP_SLLI:idec_pkg::OP_SRAI]: ctrl_d.imm_kind = idec_pkg::IMM_U5;
            idec_pkg::OP_LU12I, idec_pkg::OP_PCADDU12I: ctrl_d.imm_kind = idec_pkg::IMM_S20;
            idec_pkg::OP_JIRL, [idec_pkg::OP_BEQ:idec_pkg::OP_BGEU]:
                ctrl_d.imm_kind = idec_pkg::IMM_S16;
            idec_pkg::OP_B, idec_pkg::OP_BL: ctrl_d.imm_kind = idec_pkg::IMM_S26;
            default: ;
        endcase

        // ************************************************************
        // branch and memory controls
        // ************************************************************
        case (cls)
            idec_pkg::OP_BEQ:  ctrl_d.cmp = idec_pkg::CMP_EQ;
            idec_pkg::OP_BNE:  ctrl_d.cmp = idec_pkg::CMP_NE;
            idec_pkg::OP_BLT:  ctrl_d.cmp = idec_pkg::CMP_LT;
            idec_pkg::OP_BGE:  ctrl_d.cmp = idec_pkg::CMP_GE;
            idec_pkg::OP_BLTU: ctrl_d.cmp = idec_pkg::CMP_LTU;
            idec_pkg::OP_BGEU: ctrl_d.cmp = idec_pkg::CMP_GEU;
            default: ;
        endcase
        ctrl_d.jump       = cls inside {[idec_pkg::OP_JIRL:idec_pkg::OP_BGEU]};
        ctrl_d.target_abs = (cls == idec_pkg::OP_JIRL); // rj plus offset, the rest are pc relative
        ctrl_d.mem_read   = cls inside {[idec_pkg::OP_LDB:idec_pkg::OP_LDHU]};
        ctrl_d.mem_write  = cls inside {[idec_pkg::OP_STB:idec_pkg::OP_STW]};

        case (cls)
            idec_pkg::OP_LDH, idec_pkg::OP_STH: ctrl_d.mem_type = idec_pkg::MEM_HALF;
            idec_pkg::OP_LDW, idec_pkg::OP_STW: ctrl_d.mem_type = idec_pkg::MEM_WORD;
            idec_pkg::OP_LDBU:                  ctrl_d.mem_type = idec_pkg::MEM_UBYTE;
            idec_pkg::OP_LDHU:                  ctrl_d.mem_type = idec_pkg::MEM_UHALF;
            default:                            ctrl_d.mem_type = idec_pkg::MEM_BYTE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        ctrl_o <= ctrl_d;
        if (!rst_n_i) begin
            ctrl_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/operand_extract_stage.sv
`timescale 1ns/100ps
`default_nettype none

module operand_extract_stage (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire idec_pkg::ctrl_s   ctrl_i,
    output logic                   valid_o,
    output idec_pkg::decoded_s     dec_o
);

    idec_pkg::inst_fmt_u fmt;
    idec_pkg::decoded_s  dec_d;

    assign fmt = ctrl_i.inst;

    always_comb begin
        dec_d            = '0; // unused indices stay zero
        dec_d.err        = ctrl_i.err;
        dec_d.alu_gtype  = ctrl_i.alu_gtype;
        dec_d.alu_stype  = ctrl_i.alu_stype;
        dec_d.cmp        = ctrl_i.cmp;
        dec_d.jump       = ctrl_i.jump;
        dec_d.target_abs = ctrl_i.target_abs;
        dec_d.mem_read   = ctrl_i.mem_read;
        dec_d.mem_write  = ctrl_i.mem_write;
        dec_d.mem_type   = ctrl_i.mem_type;

        dec_d.use_imm = (ctrl_i.src0_sel == idec_pkg::SRC0_IMM);
        case (ctrl_i.src0_sel)
            idec_pkg::SRC0_RD: begin
                dec_d.rs0_en  = 1'b1;
                dec_d.rs0_idx = fmt.fmt_3r.rd;
            end
            idec_pkg::SRC0_RK: begin
                dec_d.rs0_en  = 1'b1;
                dec_d.rs0_idx = fmt.fmt_3r.rk;
            end
            default: ;
        endcase

        dec_d.rs1_en = (ctrl_i.src1_sel == idec_pkg::SRC1_RJ);
        if (dec_d.rs1_en) begin
            dec_d.rs1_idx = fmt.fmt_3r.rj;
        end

        dec_d.wr_en = (ctrl_i.wr_sel != idec_pkg::WR_NONE);
        case (ctrl_i.wr_sel)
            idec_pkg::WR_RD:   dec_d.wr_idx = fmt.fmt_3r.rd;
            idec_pkg::WR_LINK: dec_d.wr_idx = idec_pkg::REG_IDX_W'(1); // return address register
            default: ;
        endcase

        // ************************************************************
        // immediate extension
        // ************************************************************
        case (ctrl_i.imm_kind)
            idec_pkg::IMM_U5:  dec_d.imm = {27'd0, fmt.fmt_3r.rk};
            idec_pkg::IMM_U12: dec_d.imm = {20'd0, fmt.fmt_2ri12.si12};
            idec_pkg::IMM_S12: dec_d.imm = {{20{fmt.fmt_2ri12.si12[11]}}, fmt.fmt_2ri12.si12};
            idec_pkg::IMM_S20: dec_d.imm = {fmt.fmt_1ri20.si20, 12'd0};
            idec_pkg::IMM_S16: begin
                dec_d.imm = {{14{fmt.fmt_2ri16.offs16[15]}}, fmt.fmt_2ri16.offs16, 2'b00};
            end
            idec_pkg::IMM_S26: begin
                dec_d.imm = {{4{fmt.fmt_i26.offs_hi10[9]}}, fmt.fmt_i26.offs_hi10,
                             fmt.fmt_i26.offs16, 2'b00};
            end
            default: dec_d.imm = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= ctrl_i.valid;
        end
        dec_o <= dec_d;
    end

endmodule

`default_nettype wire

// File: design/inst_decode_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode_pipe (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         valid_i,
    input  wire [idec_pkg::INST_W-1:0]  inst_i,
    output logic                        valid_o,
    output idec_pkg::decoded_s          dec_o
);

    idec_pkg::match_s s1_match; // class and raw word after the first edge
    idec_pkg::ctrl_s  s2_ctrl;

    opcode_match_stage i_match (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .match_o (s1_match)
    );

    control_gen_stage i_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .match_i (s1_match),
        .ctrl_o  (s2_ctrl)
    );

    operand_extract_stage i_operand (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ctrl_i  (s2_ctrl),
        .valid_o (valid_o),
        .dec_o   (dec_o)
    );

endmodule

`default_nettype wire

// File: dv/inst_decode_pipe_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode_pipe_assertions (
    input wire                     clk_i,
    input wire                     rst_n_i,
    input wire                     valid_i,
    input wire                     valid_o,
    input wire idec_pkg::decoded_s dec_o
);

    int unsigned fail_cnt = 0; // number of failed properties so far

    // three stages, so the strobe comes out three edges later
    valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o == $past(valid_i, 3))
        else begin
            $error("valid_o does not follow valid_i by three cycles");
            fail_cnt++;
        end

    err_no_enables: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && dec_o.err) |-> !(dec_o.mem_read || dec_o.mem_write || dec_o.jump ||
            dec_o.rs0_en || dec_o.rs1_en || dec_o.wr_en || dec_o.use_imm))
        else begin
            $error("error item carries an enable");
            fail_cnt++;
        end

    mem_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> !(dec_o.mem_read && dec_o.mem_write))
        else begin
            $error("mem_read and mem_write both set");
            fail_cnt++;
        end

endmodule

bind inst_decode_pipe inst_decode_pipe_assertions i_assertions (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .dec_o   (dec_o)
);

`default_nettype wire

// File: dv/inst_decode_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode_pipe_tb;

    localparam int unsigned NUM_WORDS  = 2000;
    localparam int unsigned MAX_CYCLES = 3000;
    localparam int unsigned NUM_OPS    = 42;

    logic                        clk;
    logic                        rst_n_i;
    logic                        valid_i;
    logic [idec_pkg::INST_W-1:0] inst_i;
    logic                        valid_o;
    idec_pkg::decoded_s          dec_o;

    integer                      seed;
    int unsigned                 cycles;
    idec_pkg::decoded_s          exp_q[$];

    // the last three opcode fields are dropped ones (mul.w, div.w, syscall)
    logic [16:0] op_val [NUM_OPS] = '{
        17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29, 17'h2a, 17'h2b, 17'h2e, 17'h2f,
        17'h30, 17'h81, 17'h89, 17'h91, 17'h008, 17'h009, 17'h00a, 17'h00d, 17'h00e,
        17'h00f, 17'h0a0, 17'h0a1, 17'h0a2, 17'h0a4, 17'h0a5, 17'h0a6, 17'h0a8, 17'h0a9,
        17'h0a, 17'h0e, 17'h13, 17'h14, 17'h15, 17'h16, 17'h17, 17'h18, 17'h19, 17'h1a,
        17'h1b, 17'h38, 17'h40, 17'h56
    };
    int unsigned op_len [NUM_OPS] = '{
        17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 17, 10, 10, 10, 10, 10, 10,
        10, 10, 10, 10, 10, 10, 10, 10, 7, 7, 6, 6, 6, 6, 6, 6, 6, 6, 6, 17, 17, 17
    };

    inst_decode_pipe i_dut (
        .clk_i   (clk),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .valid_o (valid_o),
        .dec_o   (dec_o)
    );

    always #20 clk = ~clk;

    // ************************************************************
    // reference model
    // ************************************************************

    function automatic idec_pkg::decoded_s decode_ref(input logic [31:0] w);
        idec_pkg::decoded_s d;
        int                 grp;
        logic [4:0]         gs;
        logic [11:0]        row;
        logic [1:0]         src0;
        logic               rs1;
        logic [1:0]         wr;
        logic [2:0]         immk;
        d   = '0;
        grp = 0;
        gs  = '0;
        case (w[31:15])
            17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29, 17'h2a, 17'h2b,
            17'h2e, 17'h2f, 17'h30: grp = 1;
            17'h81, 17'h89, 17'h91: grp = 2;
            default: ;
        endcase
        case (w[31:22])
            10'h008, 10'h009, 10'h00a: grp = 3;
            10'h00d, 10'h00e, 10'h00f: grp = 4;
            10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9: grp = 5;
            10'h0a4, 10'h0a5, 10'h0a6: grp = 6;
            default: ;
        endcase
        if (w[31:25] == 7'h0a || w[31:25] == 7'h0e) grp = 7;
        case (w[31:26])
            6'h13: grp = 8;
            6'h14, 6'h15: grp = 9;
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: grp = 10;
            default: ;
        endcase

        case (w[31:15])
            17'h22: gs = {idec_pkg::GTYPE_INT, idec_pkg::ALU_SUB};
            17'h24: gs = {idec_pkg::GTYPE_INT, idec_pkg::ALU_SLT};
            17'h25: gs = {idec_pkg::GTYPE_INT, idec_pkg::ALU_SLTU};
            17'h28: gs = {idec_pkg::GTYPE_BW, idec_pkg::ALU_NOR};
            17'h29: gs = {idec_pkg::GTYPE_BW, idec_pkg::ALU_AND};
            17'h2a: gs = {idec_pkg::GTYPE_BW, idec_pkg::ALU_OR};
            17'h2b: gs = {idec_pkg::GTYPE_BW, idec_pkg::ALU_XOR};
            17'h2e, 17'h81: gs = {idec_pkg::GTYPE_SFT, idec_pkg::ALU_SLL};
            17'h2f, 17'h89: gs = {idec_pkg::GTYPE_SFT, idec_pkg::ALU_SRL};
            17'h30, 17'h91: gs = {idec_pkg::GTYPE_SFT, idec_pkg::ALU_SRA};
            default: ;
        endcase
        case (w[31:22])
            10'h008: gs = {idec_pkg::GTYPE_INT, idec_pkg::ALU_SLT};
            10'h009: gs = {idec_pkg::GTYPE_INT, idec_pkg::ALU_SLTU};
            10'h00d: gs = {idec_pkg::GTYPE_BW, idec_pkg::ALU_AND};
            10'h00e: gs = {idec_pkg::GTYPE_BW, idec_pkg::ALU_OR};
            10'h00f: gs = {idec_pkg::GTYPE_BW, idec_pkg::ALU_XOR};
            default: ;
        endcase
        if (grp == 7) begin
            gs = (w[31:25] == 7'h0e) ? {idec_pkg::GTYPE_LI, idec_pkg::ALU_PCADDUI}
                                     : {idec_pkg::GTYPE_LI, idec_pkg::ALU_LUI};
        end
        if (grp == 8 || w[31:26] == 6'h15) gs = {idec_pkg::GTYPE_LI, idec_pkg::ALU_PCPLUS4};

        // src0 (1 rd, 2 rk, 3 imm), rs1, wr (1 rd, 2 link), imm kind, jump, abs, load, store
        case (grp)
            1:  row = {2'd2, 1'b1, 2'd1, 3'd0, 4'b0000};
            2:  row = {2'd3, 1'b1, 2'd1, 3'd1, 4'b0000};
            3:  row = {2'd3, 1'b1, 2'd1, 3'd3, 4'b0000};
            4:  row = {2'd3, 1'b1, 2'd1, 3'd2, 4'b0000};
            5:  row = {2'd0, 1'b1, 2'd1, 3'd3, 4'b0010};
            6:  row = {2'd1, 1'b1, 2'd0, 3'd3, 4'b0001};
            7:  row = {2'd3, 1'b0, 2'd1, 3'd4, 4'b0000};
            8:  row = {2'd0, 1'b1, 2'd1, 3'd5, 4'b1100};
            9:  row = {2'd0, 1'b0, (w[26] ? 2'd2 : 2'd0), 3'd6, 4'b1000};
            10: row = {2'd1, 1'b1, 2'd0, 3'd5, 4'b1000};
            default: row = '0;
        endcase
        {src0, rs1, wr, immk, d.jump, d.target_abs, d.mem_read, d.mem_write} = row;

        if (grp == 5 || grp == 6) begin
            case (w[25:22])
                4'h1, 4'h5: d.mem_type = idec_pkg::MEM_HALF;
                4'h2, 4'h6: d.mem_type = idec_pkg::MEM_WORD;
                4'h8:       d.mem_type = idec_pkg::MEM_UBYTE;
                4'h9:       d.mem_type = idec_pkg::MEM_UHALF;
                default:    d.mem_type = idec_pkg::MEM_BYTE;
            endcase
        end
        if (grp == 10) d.cmp = idec_pkg::cmp_e'(w[31:26] - 6'h15); // beq..bgeu follow cmp order

        d.err        = (grp == 0);
        d.alu_gtype  = idec_pkg::alu_gtype_e'(gs[4:3]);
        d.alu_stype  = gs[2:0];
        d.use_imm    = (src0 == 2'd3);
        d.rs0_en     = (src0 == 2'd1 || src0 == 2'd2);
        d.rs0_idx    = (src0 == 2'd1) ? w[4:0] : (src0 == 2'd2) ? w[14:10] : 5'd0;
        d.rs1_en     = rs1;
        d.rs1_idx    = rs1 ? w[9:5] : 5'd0;
        d.wr_en      = (wr != 2'd0);
        d.wr_idx     = (wr == 2'd1) ? w[4:0] : (wr == 2'd2) ? 5'd1 : 5'd0;
        case (immk)
            3'd1:    d.imm = {27'd0, w[14:10]};
            3'd2:    d.imm = {20'd0, w[21:10]};
            3'd3:    d.imm = {{20{w[21]}}, w[21:10]};
            3'd4:    d.imm = {w[24:5], 12'd0};
            3'd5:    d.imm = {{14{w[25]}}, w[25:10], 2'b00};
            3'd6:    d.imm = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            default: d.imm = '0;
        endcase
        return d;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] r;
        int unsigned idx;
        r = $random(seed);
        if ({$random(seed)} % 4 == 0) return r; // fully random word
        idx = {$random(seed)} % NUM_OPS;
        return ({15'd0, op_val[idx]} << (32 - op_len[idx])) | (r & (32'hffff_ffff >> op_len[idx]));
    endfunction

    // ************************************************************
    // checking
    // ************************************************************

    task automatic stop_on_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_on_error("timeout, the run went past its cycle limit");
        end else if (rst_n_i && valid_i) begin
            exp_q.push_back(decode_ref(inst_i));
        end
    end

    always @(negedge clk) begin : compare_out
        idec_pkg::decoded_s exp_rec;
        if (i_dut.i_assertions.fail_cnt != 0) begin
            stop_on_error("an assertion on the DUT ports failed");
        end else if (cycles > 1 && $isunknown(valid_o)) begin
            stop_on_error("valid_o is unknown");
        end else if (valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_on_error("unexpected output with no word in flight");
            end else begin
                exp_rec = exp_q.pop_front();
                check_val("dec_o", exp_rec, dec_o);
            end
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************

    initial begin
        int unsigned sent;
        seed    = 44;
        sent    = 0;
        cycles  = 0;
        clk     = 1'b0;
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        inst_i  = '0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        while (sent < NUM_WORDS) begin
            @(negedge clk);
            inst_i = random_word();
            if ({$random(seed)} % 8 == 0) begin
                valid_i = 1'b0; // gap
            end else begin
                valid_i = 1'b1;
                sent++;
            end
        end
        @(negedge clk);
        valid_i = 1'b0;
        repeat (3) @(negedge clk); // the last word is out three edges after it went in
        if (exp_q.size() != 0) begin
            stop_on_error("expected outputs were still missing at the end");
        end else if (i_dut.i_assertions.fail_cnt != 0) begin
            stop_on_error("an assertion on the DUT ports failed");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: inst_decode_pipe.f
design/idec_pkg.sv
design/opcode_match_stage.sv
design/control_gen_stage.sv
design/operand_extract_stage.sv
design/inst_decode_pipe.sv
dv/inst_decode_pipe_assertions.sv
dv/inst_decode_pipe_tb.sv

// File: Bender.yml
package:
  name: inst_decode_pipe

sources:
  - files:
      - design/idec_pkg.sv
      - design/opcode_match_stage.sv
      - design/control_gen_stage.sv
      - design/operand_extract_stage.sv
      - design/inst_decode_pipe.sv
  - target: test
    files:
      - dv/inst_decode_pipe_assertions.sv
      - dv/inst_decode_pipe_tb.sv
